// File: src/fir_pkg.sv
package fir_pkg;

	// axi4-lite bus widths
	localparam int AXI_DATA_W = 32;
	localparam int AXI_ADDR_W = 16;
	// byte address to word index
	localparam int ADDR_LSB = 2;
	localparam int WORD_ADDR_W = AXI_ADDR_W - ADDR_LSB;

	// filter arithmetic widths
	localparam int SAMPLE_W = 14;
	localparam int COEF_W = 18;
	// room for 64 full-scale products
	localparam int ACC_W = 40;
	// coefficients are q1.17
	localparam int COEF_FRAC = 17;

	typedef logic [AXI_DATA_W-1:0] axi_data_t;
	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
	typedef logic [WORD_ADDR_W-1:0] word_addr_t;
	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [COEF_W-1:0] coef_t;
	typedef logic signed [ACC_W-1:0] acc_t;

	// bresp / rresp code
	localparam logic [1:0] RESP_OKAY = 2'b00;

	// register map, word addresses
	localparam word_addr_t REG_INFO_NAME = 14'd0;
	localparam word_addr_t REG_INFO_VER = 14'd1;
	localparam word_addr_t REG_TAP_COUNT = 14'd2;
	localparam word_addr_t REG_SWITCHES = 14'd4;
	localparam word_addr_t REG_COEF_BASE = 14'd8;

	// "_RIF" and "2MT", byte-reversed ascii
	localparam axi_data_t INFO_NAME_WORD = 32'h5F524946;
	localparam axi_data_t INFO_VER_WORD = 32'h00324D54;

	// switch bit that turns filtering on
	localparam int SW_FIR_EN = 1;
	localparam int LED_WIDTH = 8;

	// one register write, controller to register bank
	typedef struct packed {
		logic strobe;
		word_addr_t addr;
		axi_data_t data;
	} reg_wr_t;

endpackage

// File: src/axi_lite_ctrl_fsm.sv
`timescale 1ns/1ps

module axi_lite_ctrl_fsm (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// write address and data
	input fir_pkg::axi_addr_t i_s_axi_awaddr,
	input logic i_s_axi_awvalid,
	output logic o_s_axi_awready,
	input fir_pkg::axi_data_t i_s_axi_wdata,
	input logic [fir_pkg::AXI_DATA_W/8-1:0] i_s_axi_wstrb,
	input logic i_s_axi_wvalid,
	output logic o_s_axi_wready,
	// write response
	output logic [1:0] o_s_axi_bresp,
	output logic o_s_axi_bvalid,
	input logic i_s_axi_bready,
	// read address and data
	input fir_pkg::axi_addr_t i_s_axi_araddr,
	input logic i_s_axi_arvalid,
	output logic o_s_axi_arready,
	output fir_pkg::axi_data_t o_s_axi_rdata,
	output logic [1:0] o_s_axi_rresp,
	output logic o_s_axi_rvalid,
	input logic i_s_axi_rready,
	// register bank side
	output fir_pkg::reg_wr_t o_reg_wr,
	output fir_pkg::word_addr_t o_rd_addr,
	input fir_pkg::axi_data_t i_rd_data
);

	import fir_pkg::*;

	typedef enum logic {W_IDLE, W_RESP} wr_state_t;
	typedef enum logic {R_IDLE, R_DATA} rd_state_t;

	wr_state_t wr_state;
	rd_state_t rd_state;

	logic wr_accept;
	logic rd_accept;
	logic wr_strobe;
	word_addr_t wr_addr_q;
	axi_data_t wr_data_q;
	word_addr_t rd_addr_q;
	axi_data_t rdata_q;

	// aw and w taken together only when no response is pending
	assign wr_accept = (wr_state == W_IDLE) && i_s_axi_awvalid && i_s_axi_wvalid;
	assign rd_accept = (rd_state == R_IDLE) && i_s_axi_arvalid;

	// write fsm
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			wr_state <= W_IDLE;
			o_s_axi_awready <= 1'b0;
			o_s_axi_wready <= 1'b0;
			o_s_axi_bvalid <= 1'b0;
			wr_strobe <= 1'b0;
		end else begin
			// ready and strobe are single-cycle pulses
			o_s_axi_awready <= 1'b0;
			o_s_axi_wready <= 1'b0;
			wr_strobe <= 1'b0;
			case (wr_state)
				W_IDLE: begin
					if (wr_accept) begin
						o_s_axi_awready <= 1'b1;
						o_s_axi_wready <= 1'b1;
						wr_strobe <= 1'b1;
						wr_state <= W_RESP;
					end
				end
				W_RESP: begin
					// response follows the ready pulse
					if (o_s_axi_awready) begin
						o_s_axi_bvalid <= 1'b1;
					end else if (o_s_axi_bvalid && i_s_axi_bready) begin
						o_s_axi_bvalid <= 1'b0;
						wr_state <= W_IDLE;
					end
				end
				default: wr_state <= W_IDLE;
			endcase
		end
	end

	// write address and data capture
	always_ff @(posedge S_AXI_ACLK) begin
		if (wr_accept) begin
			wr_addr_q <= i_s_axi_awaddr[AXI_ADDR_W-1:ADDR_LSB];
			wr_data_q <= i_s_axi_wdata;
		end
	end

	// read fsm
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			rd_state <= R_IDLE;
			o_s_axi_arready <= 1'b0;
			o_s_axi_rvalid <= 1'b0;
		end else begin
			o_s_axi_arready <= 1'b0;
			case (rd_state)
				R_IDLE: begin
					if (rd_accept) begin
						o_s_axi_arready <= 1'b1;
						rd_state <= R_DATA;
					end
				end
				R_DATA: begin
					// decoded data is ready one cycle after the address latch
					if (o_s_axi_arready) begin
						o_s_axi_rvalid <= 1'b1;
					end else if (o_s_axi_rvalid && i_s_axi_rready) begin
						o_s_axi_rvalid <= 1'b0;
						rd_state <= R_IDLE;
					end
				end
				default: rd_state <= R_IDLE;
			endcase
		end
	end

	// read address latch and read data register
	always_ff @(posedge S_AXI_ACLK) begin
		if (rd_accept) begin
			rd_addr_q <= i_s_axi_araddr[AXI_ADDR_W-1:ADDR_LSB];
		end
		if (o_s_axi_arready) begin
			rdata_q <= i_rd_data;
		end
	end

	assign o_reg_wr = '{strobe: wr_strobe, addr: wr_addr_q, data: wr_data_q};
	assign o_rd_addr = rd_addr_q;
	assign o_s_axi_rdata = rdata_q;
	// no error responses
	assign o_s_axi_bresp = RESP_OKAY;
	assign o_s_axi_rresp = RESP_OKAY;

	// write response held until the master takes it
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_s_axi_bvalid && !i_s_axi_bready |=> o_s_axi_bvalid);

	// read data held steady until the master takes it
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_s_axi_rvalid && !i_s_axi_rready |=> o_s_axi_rvalid && $stable(o_s_axi_rdata));

endmodule

// File: src/fir_reg_bank.sv
`timescale 1ns/1ps

module fir_reg_bank #(
	parameter int FIR_DSP_NR = 4,
	parameter int FIR_TM = 2,
	localparam int FIR_TAPS = FIR_TM * FIR_DSP_NR
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// register write from the controller
	input fir_pkg::reg_wr_t i_reg_wr,
	// read decode
	input fir_pkg::word_addr_t i_rd_addr,
	output fir_pkg::axi_data_t o_rd_data,
	// filter control
	output logic o_fir_en,
	output fir_pkg::coef_t [FIR_TAPS-1:0] o_coefs,
	output logic [fir_pkg::LED_WIDTH-1:0] o_leds
);

	import fir_pkg::*;

	axi_data_t switches;
	coef_t [FIR_TAPS-1:0] coefs;

	// switch word
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			switches <= '0;
		end else if (i_reg_wr.strobe && (i_reg_wr.addr == REG_SWITCHES)) begin
			switches <= i_reg_wr.data;
		end
	end

	// coefficient storage, one word per tap
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_reg_wr.strobe) begin
			for (int k = 0; k < FIR_TAPS; k++) begin
				if (i_reg_wr.addr == word_addr_t'(REG_COEF_BASE + k)) begin
					// sign from bit 31, magnitude bits from the low end
					coefs[k] <= {i_reg_wr.data[AXI_DATA_W-1], i_reg_wr.data[COEF_W-2:0]};
				end
			end
		end
	end

	// read mux, coefficients are write-only
	always_comb begin
		case (i_rd_addr)
			REG_INFO_NAME: o_rd_data = INFO_NAME_WORD;
			REG_INFO_VER: o_rd_data = INFO_VER_WORD;
			REG_TAP_COUNT: o_rd_data = axi_data_t'(FIR_TAPS);
			REG_SWITCHES: o_rd_data = switches;
			default: o_rd_data = '0;
		endcase
	end

	assign o_fir_en = switches[SW_FIR_EN];
	assign o_coefs = coefs;
	// leds mirror the low switch bits
	assign o_leds = switches[LED_WIDTH-1:0];

endmodule

// File: src/fir_phase_counter.sv
`timescale 1ns/1ps

module fir_phase_counter #(
	parameter int FIR_TM = 2,
	localparam int PHASE_W = (FIR_TM > 1) ? $clog2(FIR_TM) : 1
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic i_start,
	output logic [PHASE_W-1:0] o_phase,
	output logic o_mac_en,
	output logic o_done,
	output logic o_busy
);

	typedef enum logic [1:0] {PC_IDLE, PC_MAC, PC_DONE} pc_state_t;

	pc_state_t state;
	logic [PHASE_W-1:0] phase;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			state <= PC_IDLE;
			phase <= '0;
		end else begin
			case (state)
				PC_IDLE: begin
					// start is only honoured while idle
					if (i_start) begin
						state <= PC_MAC;
						phase <= '0;
					end
				end
				PC_MAC: begin
					if (phase == PHASE_W'(FIR_TM - 1)) begin
						state <= PC_DONE;
						phase <= '0;
					end else begin
						phase <= phase + 1'b1;
					end
				end
				// one cycle for the output load
				PC_DONE: state <= PC_IDLE;
				default: state <= PC_IDLE;
			endcase
		end
	end

	assign o_phase = phase;
	assign o_mac_en = (state == PC_MAC);
	assign o_done = (state == PC_DONE);
	assign o_busy = (state != PC_IDLE);

	// each done closes a pass accepted FIR_TM+1 edges earlier
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_done |-> $past(i_start && !o_busy, FIR_TM + 1));

endmodule

// File: src/fir_mac_datapath.sv
`timescale 1ns/1ps

module fir_mac_datapath #(
	parameter int FIR_DSP_NR = 4,
	parameter int FIR_TM = 2,
	localparam int FIR_TAPS = FIR_TM * FIR_DSP_NR,
	localparam int PHASE_W = (FIR_TM > 1) ? $clog2(FIR_TM) : 1
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// new sample and its load strobe
	input fir_pkg::sample_t i_sample,
	input logic i_load,
	// sequencing from the phase counter
	input logic [PHASE_W-1:0] i_phase,
	input logic i_mac_en,
	input logic i_done,
	// control from the register bank
	input logic i_fir_en,
	input fir_pkg::coef_t [FIR_TAPS-1:0] i_coefs,
	output fir_pkg::sample_t o_fir_out,
	output logic o_fir_valid
);

	import fir_pkg::*;

	localparam int TAP_W = (FIR_TAPS > 1) ? $clog2(FIR_TAPS) : 1;

	sample_t [FIR_TAPS-1:0] hist;
	acc_t acc;
	acc_t acc_scaled;
	acc_t mac_sum;
	acc_t prod [FIR_DSP_NR];
	logic [TAP_W-1:0] tap_idx [FIR_DSP_NR];

	// history line, entry 0 is the newest sample
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			hist <= '0;
		end else if (i_load) begin
			for (int k = FIR_TAPS - 1; k > 0; k--) begin
				hist[k] <= hist[k-1];
			end
			hist[0] <= i_sample;
		end
	end

	// one multiplier per dsp lane
	// lane d handles tap FIR_DSP_NR*phase+d
	for (genvar d = 0; d < FIR_DSP_NR; d++) begin : g_mult
		assign tap_idx[d] = TAP_W'(FIR_DSP_NR * int'(i_phase) + d);
		assign prod[d] = acc_t'(i_coefs[tap_idx[d]]) * acc_t'(hist[tap_idx[d]]);
	end

	// adder tree over the lanes
	always_comb begin
		mac_sum = '0;
		for (int d = 0; d < FIR_DSP_NR; d++) begin
			mac_sum = mac_sum + prod[d];
		end
	end

	// accumulator, cleared with each new sample
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_load) begin
			acc <= '0;
		end else if (i_mac_en) begin
			acc <= acc + mac_sum;
		end
	end

	// drop fraction bits, top bits wrap on truncation
	assign acc_scaled = acc >>> COEF_FRAC;

	// output select, filtered or raw newest sample
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_done) begin
			o_fir_out <= i_fir_en ? acc_scaled[SAMPLE_W-1:0] : hist[0];
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			o_fir_valid <= 1'b0;
		end else begin
			o_fir_valid <= i_done;
		end
	end

	// one result per accepted sample
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_fir_valid |=> !o_fir_valid);

endmodule

// File: src/fir_axi_top.sv
`timescale 1ns/1ps

module fir_axi_top #(
	parameter int FIR_DSP_NR = 4,
	parameter int FIR_TM = 2
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// axi4-lite slave
	input fir_pkg::axi_addr_t i_s_axi_awaddr,
	input logic i_s_axi_awvalid,
	output logic o_s_axi_awready,
	input fir_pkg::axi_data_t i_s_axi_wdata,
	input logic [fir_pkg::AXI_DATA_W/8-1:0] i_s_axi_wstrb,
	input logic i_s_axi_wvalid,
	output logic o_s_axi_wready,
	output logic [1:0] o_s_axi_bresp,
	output logic o_s_axi_bvalid,
	input logic i_s_axi_bready,
	input fir_pkg::axi_addr_t i_s_axi_araddr,
	input logic i_s_axi_arvalid,
	output logic o_s_axi_arready,
	output fir_pkg::axi_data_t o_s_axi_rdata,
	output logic [1:0] o_s_axi_rresp,
	output logic o_s_axi_rvalid,
	input logic i_s_axi_rready,
	// sample stream
	input fir_pkg::sample_t i_sample,
	input logic i_sample_valid,
	output fir_pkg::sample_t o_fir_out,
	output logic o_fir_valid,
	output logic [fir_pkg::LED_WIDTH-1:0] o_leds
);

	import fir_pkg::*;

	localparam int FIR_TAPS = FIR_TM * FIR_DSP_NR;
	localparam int PHASE_W = (FIR_TM > 1) ? $clog2(FIR_TM) : 1;

	reg_wr_t reg_wr;
	word_addr_t rd_addr;
	axi_data_t rd_data;
	logic fir_en;
	coef_t [FIR_TAPS-1:0] coefs;
	logic [PHASE_W-1:0] phase;
	logic mac_en;
	logic done;
	logic busy;
	logic start;

	// strobes during a busy pass are dropped
	assign start = i_sample_valid && !busy;

	axi_lite_ctrl_fsm u_ctrl (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_s_axi_awaddr(i_s_axi_awaddr),
		.i_s_axi_awvalid(i_s_axi_awvalid),
		.o_s_axi_awready(o_s_axi_awready),
		.i_s_axi_wdata(i_s_axi_wdata),
		.i_s_axi_wstrb(i_s_axi_wstrb),
		.i_s_axi_wvalid(i_s_axi_wvalid),
		.o_s_axi_wready(o_s_axi_wready),
		.o_s_axi_bresp(o_s_axi_bresp),
		.o_s_axi_bvalid(o_s_axi_bvalid),
		.i_s_axi_bready(i_s_axi_bready),
		.i_s_axi_araddr(i_s_axi_araddr),
		.i_s_axi_arvalid(i_s_axi_arvalid),
		.o_s_axi_arready(o_s_axi_arready),
		.o_s_axi_rdata(o_s_axi_rdata),
		.o_s_axi_rresp(o_s_axi_rresp),
		.o_s_axi_rvalid(o_s_axi_rvalid),
		.i_s_axi_rready(i_s_axi_rready),
		.o_reg_wr(reg_wr),
		.o_rd_addr(rd_addr),
		.i_rd_data(rd_data)
	);

	fir_reg_bank #(.FIR_DSP_NR(FIR_DSP_NR), .FIR_TM(FIR_TM)) u_regs (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_reg_wr(reg_wr),
		.i_rd_addr(rd_addr),
		.o_rd_data(rd_data),
		.o_fir_en(fir_en),
		.o_coefs(coefs),
		.o_leds(o_leds)
	);

	fir_phase_counter #(.FIR_TM(FIR_TM)) u_phase (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_start(start),
		.o_phase(phase),
		.o_mac_en(mac_en),
		.o_done(done),
		.o_busy(busy)
	);

	fir_mac_datapath #(.FIR_DSP_NR(FIR_DSP_NR), .FIR_TM(FIR_TM)) u_mac (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_sample(i_sample),
		.i_load(start),
		.i_phase(phase),
		.i_mac_en(mac_en),
		.i_done(done),
		.i_fir_en(fir_en),
		.i_coefs(coefs),
		.o_fir_out(o_fir_out),
		.o_fir_valid(o_fir_valid)
	);

endmodule

// File: tests/tb_fir_axi_tasks.svh
`ifndef TB_FIR_AXI_TASKS_SVH
`define TB_FIR_AXI_TASKS_SVH

// one axi4-lite write with aw and w presented together
task automatic axi_write(input axi_addr_t addr, input axi_data_t data);
	int n;
	logic seen_ready;
	@(posedge clk);
	#1;
	awaddr = addr;
	wdata = data;
	awvalid = 1'b1;
	wvalid = 1'b1;
	bready = 1'b1;
	n = 0;
	seen_ready = 1'b0;
	// wait for the response
	while (!bvalid && n < AXI_TIMEOUT) begin
		@(posedge clk);
		#1;
		if (awready) begin
			// w is taken on the same edge as aw
			check_val("o_s_axi_wready", 32'd1, axi_data_t'(wready));
			seen_ready = 1'b1;
			awvalid = 1'b0;
			wvalid = 1'b0;
		end
		n++;
	end
	if (!bvalid) begin
		$display("timeout: no write response for address %h at %0t", addr, $time);
		other_errors++;
		timed_out = 1'b1;
	end else begin
		if (!seen_ready) begin
			$display("write response for address %h came without awready at %0t",
				addr, $time);
			other_errors++;
		end
		check_val("o_s_axi_bresp", 32'd0, axi_data_t'(bresp));
		// bready already high so the handshake completes on this edge
		@(posedge clk);
		#1;
	end
	awvalid = 1'b0;
	wvalid = 1'b0;
	bready = 1'b0;
endtask

// one axi4-lite read
task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
	int n;
	@(posedge clk);
	#1;
	araddr = addr;
	arvalid = 1'b1;
	rready = 1'b1;
	n = 0;
	data = '0;
	while (!rvalid && n < AXI_TIMEOUT) begin
		@(posedge clk);
		#1;
		if (arready) begin
			arvalid = 1'b0;
		end
		n++;
	end
	if (!rvalid) begin
		$display("timeout: no read data for address %h at %0t", addr, $time);
		other_errors++;
		timed_out = 1'b1;
	end else begin
		data = rdata;
		check_val("o_s_axi_rresp", 32'd0, axi_data_t'(rresp));
		@(posedge clk);
		#1;
	end
	arvalid = 1'b0;
	rready = 1'b0;
endtask

// one sample strobe plus an optional second strobe while busy
task automatic drive_sample(input sample_t val, input logic dup, input sample_t dup_val,
		output sample_t got);
	int n;
	@(posedge clk);
	#1;
	smp = val;
	smp_valid = 1'b1;
	// accepting edge while the filter is idle
	@(posedge clk);
	#1;
	if (dup) begin
		// lands on the first busy edge
		smp = dup_val;
	end else begin
		smp_valid = 1'b0;
	end
	n = 0;
	got = '0;
	// count edges after the accepting one
	while (!fir_valid && n < SAMPLE_TIMEOUT) begin
		@(posedge clk);
		#1;
		smp_valid = 1'b0;
		n++;
	end
	if (!fir_valid) begin
		$display("timeout: no o_fir_valid after sample %0d at %0t", val, $time);
		other_errors++;
		timed_out = 1'b1;
	end else begin
		got = fir_out;
		check_val("o_fir_valid latency", 32'(FIR_TM + 1), 32'(n));
		// valid stays low in the gap before the next sample
		repeat (FIR_TM + 2) begin
			@(posedge clk);
			#1;
			if (fir_valid) begin
				$display("unexpected extra o_fir_valid pulse at %0t", $time);
				other_errors++;
			end
		end
	end
endtask

`endif

// File: tests/tb_fir_axi.sv
`timescale 1ns/1ps

module tb_fir_axi;

	import fir_pkg::*;

	// must match the dut defaults
	localparam int FIR_DSP_NR = 4;
	localparam int FIR_TM = 2;
	localparam int FIR_TAPS = FIR_TM * FIR_DSP_NR;
	localparam int AXI_TIMEOUT = 32;
	localparam int SAMPLE_TIMEOUT = 32;
	localparam int N_RANDOM = 20;
	localparam logic [31:0] SEED = 32'h24f52504;

	// table operations
	localparam logic [2:0] OP_WR = 3'd0;
	localparam logic [2:0] OP_RD = 3'd1;
	localparam logic [2:0] OP_LED = 3'd2;
	localparam logic [2:0] OP_SMP = 3'd3;
	localparam logic [2:0] OP_RND = 3'd4;
	localparam logic [2:0] OP_BUSY = 3'd5;

	// impulse test, coef * 4096 >>> 17 rounds toward minus infinity
	localparam int IMPULSE = 4096;
	localparam int IMP_COEF [FIR_TAPS] = '{65536, 32768, -16384, 8192,
		100000, -131072, 131071, -1000};
	localparam int IMP_EXP [FIR_TAPS] = '{2048, 1024, -512, 256, 3125, -4096, 4095, -32};

	// data is the sample for sample ops, addr the busy strobe value
	typedef struct packed {
		logic [2:0] op;
		axi_addr_t addr;
		axi_data_t data;
		axi_data_t exp_val;
	} stim_t;

	logic clk;
	logic rst_n;
	axi_addr_t awaddr;
	axi_addr_t araddr;
	axi_data_t wdata;
	axi_data_t rdata;
	logic [AXI_DATA_W/8-1:0] wstrb;
	logic awvalid, awready, wvalid, wready;
	logic bvalid, bready, arvalid, arready, rvalid, rready;
	logic [1:0] bresp;
	logic [1:0] rresp;
	sample_t smp;
	sample_t fir_out;
	logic smp_valid;
	logic fir_valid;
	logic [LED_WIDTH-1:0] leds;

	int mismatches;
	int other_errors;
	logic timed_out;
	stim_t stim_q [$];
	// reference model state
	coef_t model_coef [FIR_TAPS];
	sample_t model_hist [FIR_TAPS];
	logic model_fir_en;

	fir_axi_top uut (
		.S_AXI_ACLK(clk),
		.S_AXI_ARESETN(rst_n),
		.i_s_axi_awaddr(awaddr),
		.i_s_axi_awvalid(awvalid),
		.o_s_axi_awready(awready),
		.i_s_axi_wdata(wdata),
		.i_s_axi_wstrb(wstrb),
		.i_s_axi_wvalid(wvalid),
		.o_s_axi_wready(wready),
		.o_s_axi_bresp(bresp),
		.o_s_axi_bvalid(bvalid),
		.i_s_axi_bready(bready),
		.i_s_axi_araddr(araddr),
		.i_s_axi_arvalid(arvalid),
		.o_s_axi_arready(arready),
		.o_s_axi_rdata(rdata),
		.o_s_axi_rresp(rresp),
		.o_s_axi_rvalid(rvalid),
		.i_s_axi_rready(rready),
		.i_sample(smp),
		.i_sample_valid(smp_valid),
		.o_fir_out(fir_out),
		.o_fir_valid(fir_valid),
		.o_leds(leds)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_val(input string name, input axi_data_t exp_v, input axi_data_t act);
		if (act !== exp_v) begin
			$display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
				$time, name, exp_v, act);
			mismatches++;
		end
	endtask

	`include "tb_fir_axi_tasks.svh"

	function automatic axi_addr_t byte_addr(input int word);
		return axi_addr_t'(word * 4);
	endfunction

	function automatic void add_step(input logic [2:0] op, input axi_addr_t addr,
			input axi_data_t data, input axi_data_t exp_val);
		stim_q.push_back('{op: op, addr: addr, data: data, exp_val: exp_val});
	endfunction

	// switch and coefficient writes as seen by the model
	function automatic void model_write(input axi_addr_t addr, input axi_data_t data);
		int w;
		w = int'(addr) / 4;
		if (w == int'(REG_SWITCHES)) begin
			model_fir_en = data[SW_FIR_EN];
		end else if (w >= int'(REG_COEF_BASE) && w < int'(REG_COEF_BASE) + FIR_TAPS) begin
			// sign from bit 31 over bits 16..0
			model_coef[w - int'(REG_COEF_BASE)] = {data[31], data[16:0]};
		end
	endfunction

	// shift in one sample, sum coef k times sample n-k
	function automatic sample_t model_step(input sample_t x);
		longint sum;
		sum = 0;
		for (int k = FIR_TAPS - 1; k > 0; k--) begin
			model_hist[k] = model_hist[k-1];
		end
		model_hist[0] = x;
		for (int k = 0; k < FIR_TAPS; k++) begin
			sum += longint'(model_coef[k]) * longint'(model_hist[k]);
		end
		if (!model_fir_en) begin
			return x;
		end
		// drop fraction bits then wrap to the sample width
		return sample_t'(sum >>> COEF_FRAC);
	endfunction

	function automatic void build_table();
		// bypass straight after reset
		add_step(OP_SMP, '0, axi_data_t'(1234), axi_data_t'(1234));
		// id words, tap count, unmapped and coefficient reads
		add_step(OP_RD, byte_addr(0), '0, INFO_NAME_WORD);
		add_step(OP_RD, byte_addr(1), '0, INFO_VER_WORD);
		add_step(OP_RD, byte_addr(2), '0, axi_data_t'(FIR_TAPS));
		add_step(OP_RD, byte_addr(3), '0, '0);
		add_step(OP_RD, byte_addr(int'(REG_COEF_BASE)), '0, '0);
		// switches readback, filter bit still clear
		add_step(OP_WR, byte_addr(int'(REG_SWITCHES)), 32'h0000_00A5, '0);
		add_step(OP_RD, byte_addr(int'(REG_SWITCHES)), '0, 32'h0000_00A5);
		add_step(OP_LED, '0, '0, 32'h0000_00A5);
		// flush history with zeros
		for (int k = 0; k < FIR_TAPS; k++) begin
			add_step(OP_SMP, '0, '0, '0);
		end
		for (int k = 0; k < FIR_TAPS; k++) begin
			add_step(OP_WR, byte_addr(int'(REG_COEF_BASE) + k), axi_data_t'(IMP_COEF[k]), '0);
		end
		add_step(OP_RD, byte_addr(int'(REG_COEF_BASE) + 4), '0, '0);
		add_step(OP_WR, byte_addr(int'(REG_SWITCHES)), 32'h0000_0003, '0);
		add_step(OP_LED, '0, '0, 32'h0000_0003);
		// impulse response comes out in tap order
		add_step(OP_SMP, '0, axi_data_t'(IMPULSE), axi_data_t'(IMP_EXP[0]));
		for (int k = 1; k < FIR_TAPS; k++) begin
			add_step(OP_SMP, '0, '0, axi_data_t'(IMP_EXP[k]));
		end
		for (int k = 0; k < N_RANDOM; k++) begin
			add_step(OP_RND, '0, '0, '0);
		end
		// back to bypass, busy strobe must be dropped
		add_step(OP_WR, byte_addr(int'(REG_SWITCHES)), 32'h0000_0000, '0);
		add_step(OP_LED, '0, '0, '0);
		add_step(OP_BUSY, axi_addr_t'(1111), axi_data_t'(-3000), axi_data_t'(-3000));
		add_step(OP_SMP, '0, axi_data_t'(777), axi_data_t'(777));
		add_step(OP_SMP, '0, axi_data_t'(-8192), axi_data_t'(-8192));
	endfunction

	initial begin
		stim_t st;
		sample_t x;
		sample_t y;
		sample_t got;
		axi_data_t rd;
		void'($urandom(SEED));
		mismatches = 0;
		other_errors = 0;
		timed_out = 1'b0;
		model_fir_en = 1'b0;
		for (int k = 0; k < FIR_TAPS; k++) begin
			model_coef[k] = '0;
			model_hist[k] = '0;
		end
		rst_n = 1'b0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = '1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		arvalid = 1'b0;
		rready = 1'b0;
		smp = '0;
		smp_valid = 1'b0;
		build_table();
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;
		// idle outputs after reset
		check_val("o_s_axi_bvalid", '0, axi_data_t'(bvalid));
		check_val("o_s_axi_rvalid", '0, axi_data_t'(rvalid));
		check_val("o_fir_valid", '0, axi_data_t'(fir_valid));
		check_val("o_leds", '0, axi_data_t'(leds));
		for (int i = 0; i < stim_q.size() && !timed_out; i++) begin
			st = stim_q[i];
			case (st.op)
				OP_WR: begin
					axi_write(st.addr, st.data);
					model_write(st.addr, st.data);
				end
				OP_RD: begin
					axi_read(st.addr, rd);
					if (!timed_out) check_val("o_s_axi_rdata", st.exp_val, rd);
				end
				OP_LED: check_val("o_leds", st.exp_val, axi_data_t'(leds));
				OP_SMP, OP_BUSY: begin
					x = sample_t'(st.data);
					y = model_step(x);
					drive_sample(x, st.op == OP_BUSY, sample_t'(st.addr), got);
					if (!timed_out) check_val("o_fir_out", st.exp_val, axi_data_t'(int'(got)));
				end
				OP_RND: begin
					x = sample_t'($urandom);
					y = model_step(x);
					drive_sample(x, 1'b0, '0, got);
					if (!timed_out) check_val("o_fir_out", axi_data_t'(int'(y)), axi_data_t'(int'(got)));
				end
				default: begin
					$display("table entry %0d has an unknown operation", i);
					other_errors++;
				end
			endcase
		end
		$display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+tests
src/fir_pkg.sv
src/axi_lite_ctrl_fsm.sv
src/fir_reg_bank.sv
src/fir_phase_counter.sv
src/fir_mac_datapath.sv
src/fir_axi_top.sv
tests/tb_fir_axi.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then decide from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_fir_axi -f filelist.f > sim.log 2>&1 \
	&& ./obj_dir/Vtb_fir_axi >> sim.log 2>&1
cat sim.log
grep -qx "sim passed" sim.log && exit 0 || exit 1
